// ==== verilog.f ====
+incdir+tb
hw/reduction_pkg.sv
hw/narrow_reduction_alu.sv
hw/wide_op_decoder.sv
hw/wide_reduction_unit.sv
hw/result_arbiter.sv
hw/reduction_offload_tile.sv
tb/tb_reduction_offload_tile.sv

// ==== tb/reduction_model.svh ====
//////////////////////////////
// Testbench reference model
// Galois LFSR step
// Expected reduction results
//////////////////////////////

`ifndef REDUCTION_MODEL_SVH
`define REDUCTION_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1, right shifting form
localparam logic [31:0] LfsrTaps = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ LfsrTaps;
  end
  return next;
endfunction

// Unsigned reduction at a given width, operands zero-extended to 64 bits
function automatic logic [63:0] expected_result(input red_op_e     op,
                                                input logic [63:0] a,
                                                input logic [63:0] b,
                                                input int unsigned width);
  logic [127:0] product;
  logic [63:0]  mask;
  logic [63:0]  res;
  mask    = (width >= 64) ? {64{1'b1}} : ((64'd1 << width) - 64'd1);
  product = {64'd0, a} * {64'd0, b};
  case (op)
    F_Add:   res = a + b;
    // Low half of the full product
    F_Mul:   res = product[63:0];
    F_Max:   res = (a >= b) ? a : b;
    F_Min:   res = (a <= b) ? a : b;
    default: res = '0;
  endcase
  return res & mask;
endfunction

`endif

// ==== tb/tb_reduction_offload_tile.sv ====
//////////////////////////////
// Testbench for the reduction offload tile
// Random traffic on both lanes
// Lane scoreboards and latency checks
//////////////////////////////

`timescale 1ns/1ps

module tb_reduction_offload_tile;

  import reduction_pkg::*;

  `include "reduction_model.svh"

  localparam int unsigned NW = NarrowWidthDefault;
  localparam int unsigned WW = WideWidthDefault;
  localparam int ReqPerLane    = 300;
  localparam int LatencyReqs   = 40;
  localparam int TimeoutCycles = 8 * 2 * ReqPerLane + 100;

  logic clk_i = 1'b0;
  logic rst_i;
  logic narrow_req_valid_i, narrow_req_ready_o;
  red_op_e narrow_req_op_i;
  logic [NW-1:0] narrow_req_operand1_i, narrow_req_operand2_i;
  logic wide_req_valid_i, wide_req_ready_o;
  red_op_e wide_req_op_i;
  logic [WW-1:0] wide_req_operand1_i, wide_req_operand2_i;
  logic resp_valid_o, resp_ready_i;
  lane_e resp_lane_o;
  logic [WW-1:0] resp_data_o;

  logic [31:0]   lfsr_state;
  logic [WW-1:0] narrow_exp_q[$];
  logic [WW-1:0] wide_exp_q[$];
  int            narrow_acc_q[$];
  int            wide_acc_q[$];
  int cycle_cnt = 0;
  int narrow_accepted, wide_accepted, narrow_limit, wide_limit;
  int last_wide_accept, wide_back_to_back;
  int value_errors, latency_errors, flow_errors;
  logic narrow_taken, wide_taken, random_ready, check_latency;

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  reduction_offload_tile #(
    .NarrowWidth (NW),
    .WideWidth   (WW)
  ) dut_i (.*);

  // One LFSR step per bit taken
  function automatic logic [WW-1:0] rand_bits(input int n);
    logic [WW-1:0] v;
    int            i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v          = {v[WW-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  //////////////////////////////
  // Monitor and scoreboards
  //////////////////////////////

  task automatic sample_edge();
    logic [WW-1:0] exp;
    int            acc;
    int            lat;
    logic          have;
    string         lane_name;
    narrow_taken = narrow_req_valid_i && narrow_req_ready_o;
    wide_taken   = wide_req_valid_i && wide_req_ready_o;
    if (narrow_taken) begin
      narrow_exp_q.push_back(expected_result(narrow_req_op_i, narrow_req_operand1_i,
                                             narrow_req_operand2_i, NW));
      narrow_acc_q.push_back(cycle_cnt);
      narrow_accepted++;
    end
    if (wide_taken) begin
      wide_exp_q.push_back(expected_result(wide_req_op_i, wide_req_operand1_i,
                                           wide_req_operand2_i, WW));
      // Back to back only counts while latency is checked
      if (check_latency && wide_accepted > 0 && cycle_cnt == last_wide_accept + 1) begin
        wide_back_to_back++;
      end
      last_wide_accept = cycle_cnt;
      wide_acc_q.push_back(cycle_cnt);
      wide_accepted++;
    end
    if (resp_valid_o && resp_ready_i) begin
      have      = 1'b0;
      lane_name = (resp_lane_o == LANE_WIDE) ? "wide" : "narrow";
      if (resp_lane_o == LANE_NARROW && narrow_exp_q.size() > 0) begin
        exp  = narrow_exp_q.pop_front();
        acc  = narrow_acc_q.pop_front();
        lat  = 1;
        have = 1'b1;
      end else if (resp_lane_o == LANE_WIDE && wide_exp_q.size() > 0) begin
        exp  = wide_exp_q.pop_front();
        acc  = wide_acc_q.pop_front();
        lat  = 2;
        have = 1'b1;
      end
      if (!have) begin
        flow_errors++;
        $display("Unexpected %s response at %0t with no request outstanding", lane_name, $time);
      end else begin
        if (resp_data_o !== exp) begin
          value_errors++;
          $display("Fail at %0t: %s result %h, expected %h", $time, lane_name, resp_data_o, exp);
        end
        if (check_latency && (cycle_cnt - acc) != lat) begin
          latency_errors++;
          $display("Fail at %0t: %s latency %0d cycles, expected %0d", $time, lane_name,
                   cycle_cnt - acc, lat);
        end
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // New request only once the previous one is taken
  task automatic drive_inputs();
    logic [WW-1:0] a;
    logic [WW-1:0] b;
    logic [WW-1:0] op_bits;
    if ((narrow_taken || !narrow_req_valid_i) && narrow_accepted < narrow_limit &&
        rand_bits(2) != 0) begin
      op_bits = rand_bits(2);
      a = rand_bits(NW);
      b = rand_bits(NW);
      if (rand_bits(3) == 0) b = a;
      narrow_req_valid_i    <= 1'b1;
      narrow_req_op_i       <= red_op_e'(op_bits[1:0]);
      narrow_req_operand1_i <= a[NW-1:0];
      narrow_req_operand2_i <= b[NW-1:0];
    end else if (narrow_taken || !narrow_req_valid_i) begin
      narrow_req_valid_i <= 1'b0;
    end
    if ((wide_taken || !wide_req_valid_i) && wide_accepted < wide_limit &&
        rand_bits(2) != 0) begin
      op_bits = rand_bits(2);
      a = rand_bits(WW);
      b = rand_bits(WW);
      if (rand_bits(3) == 0) b = a;
      wide_req_valid_i    <= 1'b1;
      wide_req_op_i       <= red_op_e'(op_bits[1:0]);
      wide_req_operand1_i <= a;
      wide_req_operand2_i <= b;
    end else if (wide_taken || !wide_req_valid_i) begin
      wide_req_valid_i <= 1'b0;
    end
    resp_ready_i <= random_ready ? (rand_bits(3) > 2) : 1'b1;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    sample_edge();
    drive_inputs();
  endtask

  // Send the given counts, then drain both lanes
  task automatic traffic_phase(input int narrow_n, input int wide_n, input logic rand_ready,
                               input logic lat_check);
    narrow_limit  = narrow_accepted + narrow_n;
    wide_limit    = wide_accepted + wide_n;
    random_ready  = rand_ready;
    check_latency = lat_check;
    while (narrow_accepted < narrow_limit || wide_accepted < wide_limit ||
           narrow_exp_q.size() != 0 || wide_exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  initial begin
    wait (cycle_cnt >= TimeoutCycles);
    $display("Timeout after %0d cycles with requests still open", TimeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    lfsr_state = 32'd87;
    rst_i = 1'b1;
    narrow_req_valid_i = 1'b0;
    narrow_req_op_i = F_Add;
    narrow_req_operand1_i = '0;
    narrow_req_operand2_i = '0;
    wide_req_valid_i = 1'b0;
    wide_req_op_i = F_Add;
    wide_req_operand1_i = '0;
    wide_req_operand2_i = '0;
    resp_ready_i = 1'b1;
    {narrow_accepted, wide_accepted, narrow_limit, wide_limit} = '0;
    {last_wide_accept, wide_back_to_back} = '0;
    {value_errors, latency_errors, flow_errors} = '0;
    {narrow_taken, wide_taken, random_ready, check_latency} = '0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    if (resp_valid_o !== 1'b0 || narrow_req_ready_o !== 1'b1 || wide_req_ready_o !== 1'b1) begin
      value_errors++;
      $display("Fail at %0t: after reset resp_valid %b, ready narrow %b wide %b", $time,
               resp_valid_o, narrow_req_ready_o, wide_req_ready_o);
    end
    // One lane at a time with the port always free
    traffic_phase(LatencyReqs, 0, 1'b0, 1'b1);
    traffic_phase(0, LatencyReqs, 1'b0, 1'b1);
    traffic_phase(ReqPerLane - LatencyReqs, ReqPerLane - LatencyReqs, 1'b1, 1'b0);
    random_ready  = 1'b0;
    check_latency = 1'b0;
    // Idle tail catches stray responses
    repeat (10) next_cycle();
    if (wide_back_to_back == 0) begin
      flow_errors++;
      $display("No wide requests were accepted on consecutive cycles while latency was checked");
    end
    if (narrow_accepted != ReqPerLane || wide_accepted != ReqPerLane ||
        narrow_exp_q.size() != 0 || wide_exp_q.size() != 0) begin
      flow_errors++;
      $display("Request or response counts are off: narrow %0d, wide %0d accepted",
               narrow_accepted, wide_accepted);
    end
    $display("Errors: value %0d, latency %0d, flow %0d", value_errors, latency_errors,
             flow_errors);
    if (value_errors + latency_errors + flow_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/reduction_offload_tile.sv ====
//////////////////////////////
// Reduction offload tile
// Narrow ALU, wide decoder and unit
// Shared response arbiter
//////////////////////////////

`timescale 1ns/1ps

module reduction_offload_tile #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidthDefault,
  parameter int unsigned WideWidth   = reduction_pkg::WideWidthDefault
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Narrow request
  input  logic                    narrow_req_valid_i,
  output logic                    narrow_req_ready_o,
  input  reduction_pkg::red_op_e  narrow_req_op_i,
  input  logic [NarrowWidth-1:0]  narrow_req_operand1_i,
  input  logic [NarrowWidth-1:0]  narrow_req_operand2_i,
  // Wide request
  input  logic                    wide_req_valid_i,
  output logic                    wide_req_ready_o,
  input  reduction_pkg::red_op_e  wide_req_op_i,
  input  logic [WideWidth-1:0]    wide_req_operand1_i,
  input  logic [WideWidth-1:0]    wide_req_operand2_i,
  // Response
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output reduction_pkg::lane_e    resp_lane_o,
  output logic [WideWidth-1:0]    resp_data_o
);

  import reduction_pkg::*;

  // Narrow result
  logic                   narrow_resp_valid;
  logic                   narrow_resp_ready;
  logic [NarrowWidth-1:0] narrow_resp_data;

  // Wide command and result
  unit_op_e               wide_cmd_op;
  rnd_mode_e              wide_cmd_rnd;
  logic [WideWidth-1:0]   wide_cmd_operand0;
  logic [WideWidth-1:0]   wide_cmd_operand1;
  logic [WideWidth-1:0]   wide_cmd_operand2;
  logic                   wide_resp_valid;
  logic                   wide_resp_ready;
  logic [WideWidth-1:0]   wide_resp_data;

  //////////////////////////////
  // Narrow lane
  //////////////////////////////

  narrow_reduction_alu #(
    .NarrowWidth    (NarrowWidth)
  ) i_narrow_alu (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (narrow_req_valid_i),
    .req_ready_o    (narrow_req_ready_o),
    .req_op_i       (narrow_req_op_i),
    .req_operand1_i (narrow_req_operand1_i),
    .req_operand2_i (narrow_req_operand2_i),
    .resp_valid_o   (narrow_resp_valid),
    .resp_ready_i   (narrow_resp_ready),
    .resp_data_o    (narrow_resp_data)
  );

  //////////////////////////////
  // Wide lane
  //////////////////////////////

  wide_op_decoder #(
    .WideWidth      (WideWidth)
  ) i_wide_decoder (
    .req_op_i       (wide_req_op_i),
    .req_operand1_i (wide_req_operand1_i),
    .req_operand2_i (wide_req_operand2_i),
    .cmd_op_o       (wide_cmd_op),
    .cmd_rnd_o      (wide_cmd_rnd),
    .cmd_operand0_o (wide_cmd_operand0),
    .cmd_operand1_o (wide_cmd_operand1),
    .cmd_operand2_o (wide_cmd_operand2)
  );

  wide_reduction_unit #(
    .WideWidth      (WideWidth)
  ) i_wide_unit (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_valid_i    (wide_req_valid_i),
    .cmd_ready_o    (wide_req_ready_o),
    .cmd_op_i       (wide_cmd_op),
    .cmd_rnd_i      (wide_cmd_rnd),
    .cmd_operand0_i (wide_cmd_operand0),
    .cmd_operand1_i (wide_cmd_operand1),
    .cmd_operand2_i (wide_cmd_operand2),
    .resp_valid_o   (wide_resp_valid),
    .resp_ready_i   (wide_resp_ready),
    .resp_data_o    (wide_resp_data)
  );

  // Both lanes share one response port
  result_arbiter #(
    .NarrowWidth    (NarrowWidth),
    .WideWidth      (WideWidth)
  ) i_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .narrow_valid_i (narrow_resp_valid),
    .narrow_ready_o (narrow_resp_ready),
    .narrow_data_i  (narrow_resp_data),
    .wide_valid_i   (wide_resp_valid),
    .wide_ready_o   (wide_resp_ready),
    .wide_data_i    (wide_resp_data),
    .resp_valid_o   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .resp_lane_o    (resp_lane_o),
    .resp_data_o    (resp_data_o)
  );

endmodule

// ==== hw/result_arbiter.sv ====
//////////////////////////////
// Response port arbiter
// Round robin over narrow and wide lanes
//////////////////////////////

`timescale 1ns/1ps

module result_arbiter #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidthDefault,
  parameter int unsigned WideWidth   = reduction_pkg::WideWidthDefault
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Narrow lane
  input  logic                    narrow_valid_i,
  output logic                    narrow_ready_o,
  input  logic [NarrowWidth-1:0]  narrow_data_i,
  // Wide lane
  input  logic                    wide_valid_i,
  output logic                    wide_ready_o,
  input  logic [WideWidth-1:0]    wide_data_i,
  // Shared response port
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output reduction_pkg::lane_e    resp_lane_o,
  output logic [WideWidth-1:0]    resp_data_o
);

  import reduction_pkg::*;

  lane_e                last_q;
  logic                 grant_wide;
  logic [WideWidth-1:0] narrow_ext;

  // On a tie the lane not served last time wins
  always_comb begin
    if (narrow_valid_i && wide_valid_i) begin
      grant_wide = (last_q == LANE_NARROW);
    end else begin
      grant_wide = wide_valid_i;
    end
  end

  always_comb begin
    narrow_ext                  = '0;
    narrow_ext[NarrowWidth-1:0] = narrow_data_i;
  end

  assign resp_valid_o   = narrow_valid_i | wide_valid_i;
  assign resp_lane_o    = grant_wide ? LANE_WIDE : LANE_NARROW;
  assign resp_data_o    = grant_wide ? wide_data_i : narrow_ext;
  assign narrow_ready_o = resp_ready_i & ~grant_wide;
  assign wide_ready_o   = resp_ready_i & grant_wide;

  // Reset to wide so narrow goes first
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q <= LANE_WIDE;
    end else if (resp_valid_o && resp_ready_i) begin
      last_q <= resp_lane_o;
    end
  end

endmodule

// ==== hw/wide_reduction_unit.sv ====
//////////////////////////////
// Wide reduction unit
// Two-stage pipeline, three operand slots
//////////////////////////////

`timescale 1ns/1ps

module wide_reduction_unit #(
  parameter int unsigned WideWidth = reduction_pkg::WideWidthDefault
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Command
  input  logic                      cmd_valid_i,
  output logic                      cmd_ready_o,
  input  reduction_pkg::unit_op_e   cmd_op_i,
  input  reduction_pkg::rnd_mode_e  cmd_rnd_i,
  input  logic [WideWidth-1:0]      cmd_operand0_i,
  input  logic [WideWidth-1:0]      cmd_operand1_i,
  input  logic [WideWidth-1:0]      cmd_operand2_i,
  // Result
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output logic [WideWidth-1:0]      resp_data_o
);

  import reduction_pkg::*;

  // Stage one
  logic                 s1_valid_q;
  unit_op_e             s1_op_q;
  rnd_mode_e            s1_rnd_q;
  logic [WideWidth-1:0] s1_operand0_q;
  logic [WideWidth-1:0] s1_operand1_q;
  logic [WideWidth-1:0] s1_operand2_q;
  logic                 s1_ready;

  // Stage two
  logic                 s2_valid_q;
  logic [WideWidth-1:0] s2_data_q;
  logic                 s2_ready;

  logic [WideWidth-1:0] result_d;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign s2_ready    = ~s2_valid_q | resp_ready_i;
  assign s1_ready    = ~s1_valid_q | s2_ready;
  assign cmd_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= cmd_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && s1_ready) begin
      s1_op_q       <= cmd_op_i;
      s1_rnd_q      <= cmd_rnd_i;
      s1_operand0_q <= cmd_operand0_i;
      s1_operand1_q <= cmd_operand1_i;
      s1_operand2_q <= cmd_operand2_i;
    end
  end

  always_comb begin
    unique case (s1_op_q)
      U_ADD: result_d = s1_operand1_q + s1_operand2_q;
      U_MUL: result_d = s1_operand0_q * s1_operand1_q;
      U_MINMAX: begin
        if (s1_rnd_q == RNE) begin
          result_d = (s1_operand0_q > s1_operand1_q) ? s1_operand0_q : s1_operand1_q;
        end else begin
          result_d = (s1_operand0_q < s1_operand1_q) ? s1_operand0_q : s1_operand1_q;
        end
      end
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q && s2_ready) begin
      s2_data_q <= result_d;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_data_o  = s2_data_q;

endmodule

// ==== hw/wide_op_decoder.sv ====
//////////////////////////////
// Wide command decoder
// Router op to unit command and slots
//////////////////////////////

`timescale 1ns/1ps

module wide_op_decoder #(
  parameter int unsigned WideWidth = reduction_pkg::WideWidthDefault
) (
  input  reduction_pkg::red_op_e    req_op_i,
  input  logic [WideWidth-1:0]      req_operand1_i,
  input  logic [WideWidth-1:0]      req_operand2_i,
  output reduction_pkg::unit_op_e   cmd_op_o,
  output reduction_pkg::rnd_mode_e  cmd_rnd_o,
  output logic [WideWidth-1:0]      cmd_operand0_o,
  output logic [WideWidth-1:0]      cmd_operand1_o,
  output logic [WideWidth-1:0]      cmd_operand2_o
);

  import reduction_pkg::*;

  always_comb begin
    // Defaults
    cmd_op_o       = U_ADD;
    cmd_rnd_o      = RNE;
    cmd_operand0_o = '0;
    cmd_operand1_o = '0;
    cmd_operand2_o = '0;

    unique case (req_op_i)
      // Addend slots are 1 and 2
      F_Add: begin
        cmd_op_o       = U_ADD;
        cmd_operand1_o = req_operand1_i;
        cmd_operand2_o = req_operand2_i;
      end
      F_Mul: begin
        cmd_op_o       = U_MUL;
        cmd_operand0_o = req_operand1_i;
        cmd_operand1_o = req_operand2_i;
      end
      // Min and max share one opcode, rounding field picks
      F_Max: begin
        cmd_op_o       = U_MINMAX;
        cmd_rnd_o      = RNE;
        cmd_operand0_o = req_operand1_i;
        cmd_operand1_o = req_operand2_i;
      end
      F_Min: begin
        cmd_op_o       = U_MINMAX;
        cmd_rnd_o      = RTZ;
        cmd_operand0_o = req_operand1_i;
        cmd_operand1_o = req_operand2_i;
      end
      default: begin
        cmd_op_o = U_ADD;
      end
    endcase
  end

endmodule

// ==== hw/narrow_reduction_alu.sv ====
//////////////////////////////
// Narrow integer reduction ALU
// One-entry output register
//////////////////////////////

`timescale 1ns/1ps

module narrow_reduction_alu #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidthDefault
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  reduction_pkg::red_op_e  req_op_i,
  input  logic [NarrowWidth-1:0]  req_operand1_i,
  input  logic [NarrowWidth-1:0]  req_operand2_i,
  // Result
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic [NarrowWidth-1:0]  resp_data_o
);

  import reduction_pkg::*;

  logic [NarrowWidth-1:0] result_d;
  logic [NarrowWidth-1:0] result_q;
  logic                   valid_q;
  logic                   req_fire;

  // Accept when empty or the held result leaves this cycle
  assign req_ready_o = ~valid_q | resp_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  // Unsigned compare, add and mul wrap to NarrowWidth
  always_comb begin
    unique case (req_op_i)
      F_Add: result_d = req_operand1_i + req_operand2_i;
      F_Mul: result_d = req_operand1_i * req_operand2_i;
      F_Max: begin
        result_d = (req_operand1_i > req_operand2_i) ? req_operand1_i : req_operand2_i;
      end
      F_Min: begin
        result_d = (req_operand1_i < req_operand2_i) ? req_operand1_i : req_operand2_i;
      end
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  // Result payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      result_q <= result_d;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_data_o  = result_q;

endmodule

// ==== hw/reduction_pkg.sv ====
//////////////////////////////
// Shared reduction types
// Router ops, unit ops, rounding field, lane tag
// Default operand widths
//////////////////////////////

package reduction_pkg;

  //////////////////////////////
  // Router side
  //////////////////////////////

  // Reduction operation as offered by the router
  typedef enum logic [1:0] {
    F_Add = 2'd0,
    F_Mul = 2'd1,
    F_Max = 2'd2,
    F_Min = 2'd3
  } red_op_e;

  //////////////////////////////
  // Wide unit command
  //////////////////////////////

  typedef enum logic [1:0] {
    U_ADD    = 2'd0,
    U_MUL    = 2'd1,
    U_MINMAX = 2'd2
  } unit_op_e;

  // With U_MINMAX: RNE picks max, RTZ picks min
  typedef enum logic {
    RNE = 1'b0,
    RTZ = 1'b1
  } rnd_mode_e;

  // Tag on the shared response port
  typedef enum logic {
    LANE_NARROW = 1'b0,
    LANE_WIDE   = 1'b1
  } lane_e;

  // Default widths
  localparam int unsigned NarrowWidthDefault = 32;
  localparam int unsigned WideWidthDefault   = 64;

endpackage
